/* hw/pkt_fifo_pkg.sv */
`default_nettype none

package pkt_fifo_pkg;

    // ------------------------------------------------------------------
    // Sizes
    // ------------------------------------------------------------------
    localparam int DATA_BYTES    = 4;
    localparam int BUFFER_WORDS  = 64;
    localparam int MIN_PKT_BYTES = 8;
    localparam int MAX_PKT_BYTES = 64;
    localparam int MAX_PKT_WORDS = 16;

    // One slot per minimum-size packet that fits in the buffer
    localparam int DESC_DEPTH    = 32;

    // ------------------------------------------------------------------
    // Types
    // ------------------------------------------------------------------
    typedef logic [31:0] data_t;
    typedef logic [1:0]  mty_t;
    typedef logic [5:0]  addr_t;

    // Address plus wrap bit
    typedef logic [6:0]  ptr_t;

    // Byte size, holds 64 and the oversize values seen while flushing
    typedef logic [6:0]  size_t;

    // Word index within a packet, saturates at all ones
    typedef logic [4:0]  wcnt_t;

    typedef enum logic [2:0] {
        status_ok,
        status_err,
        status_short,
        status_long
    } pkt_status_t;

endpackage : pkt_fifo_pkg

`default_nettype wire

/* hw/pkt_buffer_mem.sv */
`default_nettype none

module pkt_buffer_mem (
    input  logic                clk,

    input  logic                wr_en,
    input  pkt_fifo_pkg::addr_t wr_addr,
    input  pkt_fifo_pkg::data_t wr_data,

    input  logic                rd_en,
    input  pkt_fifo_pkg::addr_t rd_addr,
    output pkt_fifo_pkg::data_t rd_data
);
    import pkt_fifo_pkg::*;

    data_t mem [BUFFER_WORDS];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // Read data holds while rd_en is low
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule : pkt_buffer_mem

`default_nettype wire

/* hw/desc_queue.sv */
`default_nettype none

module desc_queue (
    input  logic                clk,
    input  logic                srst,

    input  logic                push,
    input  pkt_fifo_pkg::addr_t push_addr,
    input  pkt_fifo_pkg::size_t push_size,

    output logic                q_valid,
    input  logic                q_ready,
    output pkt_fifo_pkg::addr_t q_addr,
    output pkt_fifo_pkg::size_t q_size
);
    import pkt_fifo_pkg::*;

    localparam int IDX_W = $clog2(DESC_DEPTH);

    // Index plus wrap bit
    typedef logic [IDX_W:0] qptr_t;

    addr_t addr_mem [DESC_DEPTH];
    size_t size_mem [DESC_DEPTH];

    qptr_t wr_ptr;
    qptr_t rd_ptr;
    qptr_t count;

    always_ff @(posedge clk) begin
        if (push) begin
            addr_mem[wr_ptr[IDX_W-1:0]] <= push_addr;
            size_mem[wr_ptr[IDX_W-1:0]] <= push_size;
        end
    end

    always_ff @(posedge clk) begin
        if (srst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (q_valid && q_ready) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // Occupancy
    assign count   = wr_ptr - rd_ptr;
    assign q_valid = (count != '0);
    assign q_addr  = addr_mem[rd_ptr[IDX_W-1:0]];
    assign q_size  = size_mem[rd_ptr[IDX_W-1:0]];

endmodule : desc_queue

`default_nettype wire

/* hw/pkt_enqueue.sv */
`default_nettype none

module pkt_enqueue (
    input  logic                      clk,
    input  logic                      srst,

    input  logic                      in_valid,
    output logic                      in_ready,
    input  pkt_fifo_pkg::data_t       in_data,
    input  logic                      in_sop,
    input  logic                      in_eop,
    input  pkt_fifo_pkg::mty_t        in_mty,
    input  logic                      in_err,

    input  pkt_fifo_pkg::ptr_t        tail_ptr,

    output logic                      wr_en,
    output pkt_fifo_pkg::addr_t       wr_addr,
    output pkt_fifo_pkg::data_t       wr_data,

    output logic                      push,
    output pkt_fifo_pkg::addr_t       push_addr,
    output pkt_fifo_pkg::size_t       push_size,

    output logic                      evt,
    output pkt_fifo_pkg::size_t       evt_size,
    output pkt_fifo_pkg::pkt_status_t evt_status
);
    import pkt_fifo_pkg::*;

    typedef enum logic [1:0] {
        st_reset,
        st_sop,
        st_mop,
        st_flush
    } state_t;

    state_t      state;
    state_t      nxt_state;

    ptr_t        wr_ptr;
    ptr_t        nxt_wr_ptr;
    ptr_t        head_ptr;
    ptr_t        fill;

    wcnt_t       word_cnt;
    wcnt_t       cur_words;
    size_t       pkt_size;

    logic        accept;
    logic        pkt_done;
    pkt_status_t pkt_status;

    // ------------------------------------------------------------------
    // Input ready, registered from the buffer fill level
    // ------------------------------------------------------------------
    assign fill = wr_ptr - tail_ptr;

    always_ff @(posedge clk) begin
        if (srst) begin
            in_ready <= 1'b0;
        end else begin
            in_ready <= (fill <= ptr_t'(BUFFER_WORDS - 2));
        end
    end

    assign accept = in_valid && in_ready;

    // Restart the word index on sop
    assign cur_words = in_sop ? wcnt_t'(1) : word_cnt;
    assign pkt_size  = size_t'(cur_words) * size_t'(DATA_BYTES) - size_t'(in_mty);

    // ------------------------------------------------------------------
    // Write FSM
    // ------------------------------------------------------------------
    always_comb begin
        nxt_state  = state;
        nxt_wr_ptr = wr_ptr;
        pkt_done   = 1'b0;
        pkt_status = status_ok;
        wr_en      = 1'b0;
        case (state)
            st_reset: nxt_state = st_sop;
            st_sop, st_mop: begin
                if (accept) begin
                    wr_en      = 1'b1;
                    nxt_wr_ptr = wr_ptr + 1'b1;
                    if (in_eop) begin
                        pkt_done = 1'b1;
                        if (in_err) begin
                            pkt_status = status_err;
                        end else if (pkt_size < size_t'(MIN_PKT_BYTES)) begin
                            pkt_status = status_short;
                        end else if (pkt_size > size_t'(MAX_PKT_BYTES)) begin
                            pkt_status = status_long;
                        end
                        // Drop everything written since the packet start
                        if (pkt_status != status_ok) begin
                            nxt_wr_ptr = head_ptr;
                        end
                        nxt_state = st_sop;
                    end else if (cur_words == wcnt_t'(MAX_PKT_WORDS)) begin
                        nxt_wr_ptr = head_ptr;
                        nxt_state  = st_flush;
                    end else begin
                        nxt_state = st_mop;
                    end
                end
            end
            st_flush: begin
                // Discard until the end of the oversize packet
                if (accept && in_eop) begin
                    pkt_done   = 1'b1;
                    pkt_status = in_err ? status_err : status_long;
                    nxt_state  = st_sop;
                end
            end
            default: nxt_state = st_reset;
        endcase
    end

    always_ff @(posedge clk) begin
        if (srst) begin
            state    <= st_reset;
            wr_ptr   <= '0;
            head_ptr <= '0;
            word_cnt <= wcnt_t'(1);
        end else begin
            state  <= nxt_state;
            wr_ptr <= nxt_wr_ptr;
            if (pkt_done && pkt_status == status_ok) begin
                head_ptr <= nxt_wr_ptr;
            end
            if (pkt_done) begin
                word_cnt <= wcnt_t'(1);
            end else if (accept && cur_words != '1) begin
                word_cnt <= cur_words + 1'b1;
            end
        end
    end

    assign wr_addr = addr_t'(wr_ptr);
    assign wr_data = in_data;

    // ------------------------------------------------------------------
    // Descriptor push and event report, one cycle after eop
    // ------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (srst) begin
            push <= 1'b0;
            evt  <= 1'b0;
        end else begin
            push <= pkt_done && (pkt_status == status_ok);
            evt  <= pkt_done;
        end
    end

    always_ff @(posedge clk) begin
        if (pkt_done) begin
            push_addr  <= addr_t'(head_ptr);
            push_size  <= pkt_size;
            evt_size   <= pkt_size;
            evt_status <= pkt_status;
        end
    end

endmodule : pkt_enqueue

`default_nettype wire

/* hw/pkt_dequeue.sv */
`default_nettype none

module pkt_dequeue (
    input  logic                clk,
    input  logic                srst,

    input  logic                q_valid,
    output logic                q_ready,
    input  pkt_fifo_pkg::addr_t q_addr,
    input  pkt_fifo_pkg::size_t q_size,

    output logic                rd_en,
    output pkt_fifo_pkg::addr_t rd_addr,
    input  pkt_fifo_pkg::data_t rd_data,

    output logic                out_valid,
    input  logic                out_ready,
    output pkt_fifo_pkg::data_t out_data,
    output logic                out_sop,
    output logic                out_eop,
    output pkt_fifo_pkg::mty_t  out_mty,

    output pkt_fifo_pkg::ptr_t  tail_ptr
);
    import pkt_fifo_pkg::*;

    typedef enum logic [1:0] {
        st_idle,
        st_read,
        st_hold
    } state_t;

    state_t state;
    state_t nxt_state;

    wcnt_t  q_words;
    mty_t   q_mty;
    wcnt_t  pkt_words;
    mty_t   pkt_mty;
    wcnt_t  rd_left;
    wcnt_t  ld_left;

    logic   pop;
    logic   rd_pend;
    logic   load;
    logic   eop_done;

    // Word count rounds up, mty is the byte shortfall of the last word
    assign q_words = wcnt_t'((q_size + size_t'(DATA_BYTES - 1)) / size_t'(DATA_BYTES));
    assign q_mty   = mty_t'(size_t'(DATA_BYTES) - q_size);

    assign q_ready = (state == st_idle);
    assign pop     = q_valid && q_ready;

    // ------------------------------------------------------------------
    // Read-ahead control
    // ------------------------------------------------------------------
    // Pending word moves into the output register when it is free
    assign load     = rd_pend && (!out_valid || out_ready);
    assign rd_en    = (state == st_read) && (!rd_pend || load);
    assign eop_done = out_valid && out_ready && out_eop;

    always_comb begin
        nxt_state = state;
        case (state)
            st_idle: begin
                if (pop) begin
                    nxt_state = st_read;
                end
            end
            st_read: begin
                if (rd_en && rd_left == wcnt_t'(1)) begin
                    nxt_state = st_hold;
                end
            end
            st_hold: begin
                if (eop_done) begin
                    nxt_state = st_idle;
                end
            end
            default: nxt_state = st_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (srst) begin
            state     <= st_idle;
            rd_pend   <= 1'b0;
            out_valid <= 1'b0;
            rd_left   <= '0;
            ld_left   <= '0;
            tail_ptr  <= '0;
        end else begin
            state   <= nxt_state;
            rd_pend <= rd_en || (rd_pend && !load);
            if (pop) begin
                rd_left <= q_words;
                ld_left <= q_words;
            end else begin
                if (rd_en) begin
                    rd_left <= rd_left - 1'b1;
                end
                if (load) begin
                    ld_left <= ld_left - 1'b1;
                end
            end
            if (load) begin
                out_valid <= 1'b1;
            end else if (out_ready) begin
                out_valid <= 1'b0;
            end
            // Release the packet's words back to enqueue
            if (eop_done) begin
                tail_ptr <= tail_ptr + ptr_t'(pkt_words);
            end
        end
    end

    // ------------------------------------------------------------------
    // Descriptor and output registers
    // ------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (pop) begin
            pkt_words <= q_words;
            pkt_mty   <= q_mty;
            rd_addr   <= q_addr;
        end else if (rd_en) begin
            rd_addr <= rd_addr + 1'b1;
        end
        if (load) begin
            out_data <= rd_data;
            out_sop  <= (ld_left == pkt_words);
            out_eop  <= (ld_left == wcnt_t'(1));
            out_mty  <= (ld_left == wcnt_t'(1)) ? pkt_mty : '0;
        end
    end

endmodule : pkt_dequeue

`default_nettype wire

/* hw/pkt_fifo_top.sv */
`default_nettype none

module pkt_fifo_top (
    input  logic                      clk,
    input  logic                      srst,

    input  logic                      in_valid,
    output logic                      in_ready,
    input  pkt_fifo_pkg::data_t       in_data,
    input  logic                      in_sop,
    input  logic                      in_eop,
    input  pkt_fifo_pkg::mty_t        in_mty,
    input  logic                      in_err,

    output logic                      out_valid,
    input  logic                      out_ready,
    output pkt_fifo_pkg::data_t       out_data,
    output logic                      out_sop,
    output logic                      out_eop,
    output pkt_fifo_pkg::mty_t        out_mty,

    output logic                      evt,
    output pkt_fifo_pkg::size_t       evt_size,
    output pkt_fifo_pkg::pkt_status_t evt_status
);
    import pkt_fifo_pkg::*;

    // Buffer write and read ports
    logic  wr_en;
    addr_t wr_addr;
    data_t wr_data;
    logic  rd_en;
    addr_t rd_addr;
    data_t rd_data;

    // Descriptor path
    logic  push;
    addr_t push_addr;
    size_t push_size;
    logic  q_valid;
    logic  q_ready;
    addr_t q_addr;
    size_t q_size;

    ptr_t  tail_ptr;

    pkt_enqueue i_enqueue (
        .clk        (clk),
        .srst       (srst),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .in_data    (in_data),
        .in_sop     (in_sop),
        .in_eop     (in_eop),
        .in_mty     (in_mty),
        .in_err     (in_err),
        .tail_ptr   (tail_ptr),
        .wr_en      (wr_en),
        .wr_addr    (wr_addr),
        .wr_data    (wr_data),
        .push       (push),
        .push_addr  (push_addr),
        .push_size  (push_size),
        .evt        (evt),
        .evt_size   (evt_size),
        .evt_status (evt_status)
    );

    pkt_buffer_mem i_mem (
        .clk     (clk),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .rd_en   (rd_en),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    desc_queue i_desc_queue (
        .clk       (clk),
        .srst      (srst),
        .push      (push),
        .push_addr (push_addr),
        .push_size (push_size),
        .q_valid   (q_valid),
        .q_ready   (q_ready),
        .q_addr    (q_addr),
        .q_size    (q_size)
    );

    pkt_dequeue i_dequeue (
        .clk       (clk),
        .srst      (srst),
        .q_valid   (q_valid),
        .q_ready   (q_ready),
        .q_addr    (q_addr),
        .q_size    (q_size),
        .rd_en     (rd_en),
        .rd_addr   (rd_addr),
        .rd_data   (rd_data),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_data  (out_data),
        .out_sop   (out_sop),
        .out_eop   (out_eop),
        .out_mty   (out_mty),
        .tail_ptr  (tail_ptr)
    );

endmodule : pkt_fifo_top

`default_nettype wire

/* verif/pkt_fifo_tb.sv */
`default_nettype none

module pkt_fifo_tb;
    import pkt_fifo_pkg::*;

    logic        clk;
    logic        srst;
    logic        in_valid;
    logic        in_ready;
    data_t       in_data;
    logic        in_sop;
    logic        in_eop;
    mty_t        in_mty;
    logic        in_err;
    logic        out_valid;
    logic        out_ready;
    data_t       out_data;
    logic        out_sop;
    logic        out_eop;
    mty_t        out_mty;
    logic        evt;
    size_t       evt_size;
    pkt_status_t evt_status;

    // One entry per line of the case file
    int case_len[$];
    int case_err[$];
    int case_stall[$];
    int case_status[$];
    int case_errs[$];

    // Expected output words as {sop, eop, mty, data}
    logic [35:0] word_q[$];
    int          word_case[$];
    int          evt_case[$];

    int     out_idx    = 0;
    int     evt_idx    = 0;
    int     out_pkts   = 0;
    int     ok_evts    = 0;
    int     mon_errs   = 0;
    int     drv_errs   = 0;
    int     ready_mode = 0;
    int     limit      = 1000;
    int     low_run    = 0;
    bit     released   = 1'b0;
    bit     bp_seen    = 1'b0;
    bit     stall_used = 1'b0;
    integer seed       = 32'hb151a8ef;

    pkt_fifo_top i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // ------------------------------------------------------------------
    // Reference rules
    // ------------------------------------------------------------------
    function automatic pkt_status_t expect_status(input int len, input int err);
        pkt_status_t st;
        if (err != 0) begin
            st = status_err;
        end else if (len < MIN_PKT_BYTES) begin
            st = status_short;
        end else if (len > MAX_PKT_BYTES) begin
            st = status_long;
        end else begin
            st = status_ok;
        end
        return st;
    endfunction

    // Byte p of packet n is n*16 + p
    // Empty lanes stay zero
    function automatic data_t payload_word(input int n, input int w, input int len);
        data_t word;
        int    p;
        word = '0;
        for (int k = 0; k < DATA_BYTES; k++) begin
            p = w * DATA_BYTES + k;
            if (p < len) begin
                word[8*k +: 8] = 8'((n * 16 + p) & 255);
            end
        end
        return word;
    endfunction

    // Result line for a case after its last check
    function automatic void report_case(input int n);
        pkt_status_t st;
        st = expect_status(case_len[n], case_err[n]);
        $display("case %0d: len %0d %s %s", n, case_len[n], st.name(),
                 (case_errs[n] == 0) ? "pass" : "FAIL");
    endfunction

    task automatic load_cases();
        int    fd;
        int    rc;
        int    len;
        int    err;
        int    stall;
        int    st;
        string line;
        fd = $fopen("verif/pkt_fifo_cases.txt", "r");
        if (fd == 0) begin
            $display("cannot open the case file verif/pkt_fifo_cases.txt");
            drv_errs++;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                rc = $fgets(line, fd);
                // Skip blank and comment lines
                if (rc != 0 && line.len() > 1 && line[0] != "#") begin
                    if ($sscanf(line, "%d %d %d %d", len, err, stall, st) == 4) begin
                        case_len.push_back(len);
                        case_err.push_back(err);
                        case_stall.push_back(stall);
                        case_status.push_back(st);
                        case_errs.push_back(0);
                    end
                end
            end
            $fclose(fd);
        end
        if (case_len.size() == 0) begin
            $display("no packets were read from the case file");
            drv_errs++;
        end
    endtask

    task automatic queue_words(input int n);
        int words;
        int mty;
        words = (case_len[n] + DATA_BYTES - 1) / DATA_BYTES;
        mty   = words * DATA_BYTES - case_len[n];
        for (int w = 0; w < words; w++) begin
            word_q.push_back({w == 0, w == words - 1,
                              (w == words - 1) ? mty_t'(mty) : mty_t'(0),
                              payload_word(n, w, case_len[n])});
            word_case.push_back(n);
        end
    endtask

    // ------------------------------------------------------------------
    // Input driver
    // ------------------------------------------------------------------
    task automatic send_packet(input int n);
        int   words;
        int   mty;
        logic taken;
        words = (case_len[n] + DATA_BYTES - 1) / DATA_BYTES;
        mty   = words * DATA_BYTES - case_len[n];
        for (int w = 0; w < words; w++) begin
            in_valid = 1'b1;
            in_data  = payload_word(n, w, case_len[n]);
            in_sop   = (w == 0);
            in_eop   = (w == words - 1);
            in_mty   = in_eop ? mty_t'(mty) : mty_t'(0);
            in_err   = in_eop && (case_err[n] != 0);
            // Hold the word until in_ready was high at an edge
            do begin
                @(negedge clk);
                taken = in_ready;
                @(posedge clk);
                #2;
            end while (!taken);
        end
        in_valid = 1'b0;
        in_sop   = 1'b0;
        in_eop   = 1'b0;
        in_mty   = '0;
        in_err   = 1'b0;
    endtask

    // Output ready per mode
    // Mode 0 high, mode 1 low until the buffer backs up, mode 2 random
    initial begin
        int rnd;
        out_ready = 1'b0;
        forever begin
            @(posedge clk);
            #1;
            if (ready_mode == 1) begin
                if (in_ready) begin
                    low_run = 0;
                end else begin
                    low_run++;
                end
                if (low_run >= 8) begin
                    released = 1'b1;
                    bp_seen  = 1'b1;
                end
                out_ready = released;
            end else begin
                low_run  = 0;
                released = 1'b0;
                if (ready_mode == 2) begin
                    rnd       = $random(seed);
                    out_ready = rnd[0];
                end else begin
                    out_ready = 1'b1;
                end
            end
        end
    end

    // ------------------------------------------------------------------
    // Output and event monitor
    // ------------------------------------------------------------------
    always @(negedge clk) begin
        logic [35:0] exp;
        pkt_status_t exp_st;
        int          n;
        int          bad;
        if (!srst && out_valid && out_ready) begin
            if (out_idx >= word_q.size()) begin
                $display("unexpected output word %h with no packet pending", out_data);
                mon_errs++;
            end else begin
                exp = word_q[out_idx];
                n   = word_case[out_idx];
                bad = 0;
                if (out_data !== exp[31:0]) begin
                    $display("mismatch case %0d out_data: got %h expected %h",
                             n, out_data, exp[31:0]);
                    bad++;
                end
                if (out_sop !== exp[35] || out_eop !== exp[34]) begin
                    $display("mismatch case %0d out_sop/out_eop: got %h/%h expected %h/%h",
                             n, out_sop, out_eop, exp[35], exp[34]);
                    bad++;
                end
                if (out_mty !== exp[33:32]) begin
                    $display("mismatch case %0d out_mty: got %h expected %h",
                             n, out_mty, exp[33:32]);
                    bad++;
                end
                mon_errs     += bad;
                case_errs[n] = case_errs[n] + bad;
                // Last word of a committed packet closes its case
                if (exp[34]) begin
                    report_case(n);
                end
                out_idx++;
            end
            if (out_eop) begin
                out_pkts++;
            end
        end
        if (!srst && evt) begin
            if (evt_status == status_ok) begin
                ok_evts++;
            end
            if (evt_idx >= evt_case.size()) begin
                $display("unexpected event with no packet pending");
                mon_errs++;
            end else begin
                n      = evt_case[evt_idx];
                exp_st = expect_status(case_len[n], case_err[n]);
                bad    = 0;
                if (evt_status !== exp_st) begin
                    $display("mismatch case %0d evt_status: got %h expected %h",
                             n, evt_status, exp_st);
                    bad++;
                end
                if (evt_size !== size_t'(case_len[n])) begin
                    $display("mismatch case %0d evt_size: got %h expected %h",
                             n, evt_size, size_t'(case_len[n]));
                    bad++;
                end
                mon_errs     += bad;
                case_errs[n] = case_errs[n] + bad;
                // Dropped packets end with their event
                if (exp_st != status_ok) begin
                    report_case(n);
                end
                evt_idx++;
            end
        end
    end

    // Watchdog with a limit set from the number of cases
    initial begin
        int cycles;
        cycles = 0;
        while (cycles < limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout after %0d cycles, packets stopped moving", cycles);
        $display("Verification failed");
        $finish;
    end

    // ------------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------------
    initial begin
        pkt_status_t st;
        int          total;
        srst     = 1'b1;
        in_valid = 1'b0;
        in_data  = '0;
        in_sop   = 1'b0;
        in_eop   = 1'b0;
        in_mty   = '0;
        in_err   = 1'b0;
        load_cases();
        limit = 200 * case_len.size() + 100;
        repeat (4) @(posedge clk);
        #2;
        srst = 1'b0;
        for (int i = 0; i < case_len.size(); i++) begin
            st = expect_status(case_len[i], case_err[i]);
            if (int'(st) != case_status[i]) begin
                $display("case %0d: file status %0d disagrees with the size and error rule",
                         i, case_status[i]);
                drv_errs++;
            end
            if (case_stall[i] == 1) begin
                stall_used = 1'b1;
            end
            ready_mode = case_stall[i];
            evt_case.push_back(i);
            if (st == status_ok) begin
                queue_words(i);
            end
            send_packet(i);
        end
        ready_mode = 0;
        while (out_idx < word_q.size() || evt_idx < evt_case.size()) begin
            @(posedge clk);
        end
        // Let any stray words or events show up
        repeat (20) @(posedge clk);
        if (stall_used && !bp_seen) begin
            $display("in_ready never fell while out_ready was held low");
            drv_errs++;
        end
        if (out_pkts != ok_evts) begin
            $display("output packet count %0d differs from ok event count %0d",
                     out_pkts, ok_evts);
            drv_errs++;
        end
        total = drv_errs + mon_errs;
        $display("%0d cases, %0d output packets, %0d errors", case_len.size(), out_pkts, total);
        if (total == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule : pkt_fifo_tb

`default_nettype wire

/* verif/pkt_fifo_cases.txt */
# len err stall status, one packet per line, decimal
# stall: 0 out_ready high, 1 held low until in_ready falls, 2 random; status: 0 ok 1 err 2 short 3 long
8 0 0 0
13 0 0 0
22 0 0 0
31 0 0 0
64 0 0 0
1 0 0 2
4 0 0 2
7 0 0 2
9 0 0 0
3 1 0 1
20 1 0 1
17 0 0 0
65 0 0 3
80 0 0 3
72 1 0 1
40 0 0 0
32 0 1 0
32 0 1 0
32 0 1 0
32 0 1 0
32 0 1 0
32 0 1 0
32 0 1 0
32 0 1 0
32 0 1 0
32 0 1 0
32 0 1 0
32 0 1 0
32 0 1 0
32 0 1 0
32 0 1 0
32 0 1 0
32 0 1 0
32 0 1 0
32 0 1 0
32 0 1 0
12 0 2 0
5 0 2 2
61 0 2 0
2 1 2 1
70 0 2 3
26 0 2 0
33 0 2 0
64 0 2 0

/* all.f */
hw/pkt_fifo_pkg.sv
hw/pkt_buffer_mem.sv
hw/desc_queue.sv
hw/pkt_enqueue.sv
hw/pkt_dequeue.sv
hw/pkt_fifo_top.sv
verif/pkt_fifo_tb.sv

/* run.sh */
#!/bin/sh
# Compile and run the packet FIFO testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module pkt_fifo_tb -f all.f -o pkt_fifo_sim
./obj_dir/pkt_fifo_sim > sim.log 2>&1
cat sim.log

if grep -q "Verification failed" sim.log; then
    exit 1
fi
exit 0
